/* filelist.f */
common/itcmPkg.sv
common/fetchPkg.sv
itcm/itcmBanked.sv
design/fetchCtrl.sv
design/fetchQueue.sv
design/instrSplitter.sv
design/fetchTop.sv
verif/tbFetchTop.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench.

VERILATOR ?= verilator
TOP ?= tbFetchTop
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Everything OK

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/tbFetchTop.sv */
`default_nettype none

module tbFetchTop;
	timeunit 1ns;
	timeprecision 1ps;

	import itcmPkg::*;
	import fetchPkg::*;

	localparam logic [31:0] SEED = 32'ha4e4_7f9f; // start of the xorshift sequence.
	localparam int IMAGE_WORDS = 2 * ITCM_DEPTH; // both banks together hold 2048 words.
	localparam int RESET_CYCLES = 8;
	localparam int SEQ_COUNT = 64; // instructions in the plain sequential stream.
	localparam int RANDOM_COUNT = 400; // instructions under random back-pressure.
	localparam int REDIRECT_ROUNDS = 24;
	localparam int REDIRECT_GAP = 16; // random idle cycles before a redirect stay below this.
	localparam int REDIRECT_AFTER = 8; // accepted instructions after each redirect.
	localparam int WRAP_COUNT = 12; // accepted instructions after each wrap target.
	localparam int WRAP_TARGETS = 3;
	localparam int LOAD_CYCLES = IMAGE_WORDS + RESET_CYCLES + 2;
	localparam int STREAM_CYCLES = SEQ_COUNT + RANDOM_COUNT
		+ REDIRECT_ROUNDS * (REDIRECT_GAP + REDIRECT_AFTER + 2)
		+ WRAP_TARGETS * (WRAP_COUNT + 2);
	localparam longint WATCHDOG_NS = longint'(LOAD_CYCLES + 4 * STREAM_CYCLES) * 40;

	logic CLK;
	logic RSTn;
	logic loadEn;
	itcmWordAddrT loadAddr;
	instrT loadData;
	logic redirectEn;
	pcT redirectPc;
	logic instrReady;
	logic instrValid;
	pcT instrPc;
	instrT instr;

	instrT image [IMAGE_WORDS]; // local copy of what the ITCM is loaded with.
	logic [31:0] rngState;
	pcT expPc; // address the next accepted instruction must have.
	int acceptCount = 0; // accepted instructions since reset.
	int mismatchErrors = 0;
	int holdErrors = 0;
	int resetErrors = 0;
	string testName = "load";

	fetchTop i_dut (
		.CLK(CLK),
		.RSTn(RSTn),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.redirectEn(redirectEn),
		.redirectPc(redirectPc),
		.instrReady(instrReady),
		.instrValid(instrValid),
		.instrPc(instrPc),
		.instr(instr)
	);

	always #20 CLK = ~CLK; // 40 ns period.

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	function automatic logic drawReady();
		return (nextRand() % 32'd10) < 32'd7; // decode ready about 70% of the time.
	endfunction

	// random upper bits exercise aliasing and the DUT drops the two low bits.
	function automatic pcT randomTarget(input logic misaligned);
		pcT t;
		t = {nextRand(), nextRand()};
		t[2] = misaligned;
		return t;
	endfunction

	// the model sits on the falling edge, where every DUT output has settled.
	always @(negedge CLK) begin
		if (!RSTn) begin
			expPc <= RESET_PC;
		end else if (redirectEn) begin
			expPc <= {redirectPc[63:2], 2'b00}; // fetch restarts at the word target.
		end else if (instrValid && instrReady) begin
			expPc <= expPc + 64'd4;
			acceptCount <= acceptCount + 1;
		end
	end

	pcCheck: assert property (@(negedge CLK) disable iff (!RSTn)
		(instrValid && instrReady) |-> (instrPc == expPc))
	else begin
		mismatchErrors = mismatchErrors + 1;
		$display("Mismatch %s pc: expected %h actual %h",
			testName, $sampled(expPc), $sampled(instrPc));
	end

	// the image index is the word address modulo the ITCM size.
	instrCheck: assert property (@(negedge CLK) disable iff (!RSTn)
		(instrValid && instrReady) |-> (instr == image[expPc[ITCM_AW+2:2]]))
	else begin
		mismatchErrors = mismatchErrors + 1;
		$display("Mismatch %s instr at %h: expected %h actual %h",
			testName, $sampled(expPc), image[$sampled(expPc[ITCM_AW+2:2])],
			$sampled(instr));
	end

	// a stalled instruction stays put until taken, unless a redirect kills it.
	holdCheck: assert property (@(negedge CLK) disable iff (!RSTn)
		(instrValid && !instrReady)
		|=> (redirectEn || (instrValid && $stable(instrPc) && $stable(instr))))
	else begin
		holdErrors = holdErrors + 1;
		$display("%s: stalled instruction changed or vanished without a redirect", testName);
	end

	resetCheck: assert property (@(negedge CLK)
		(!RSTn || !$past(RSTn)) |-> !instrValid)
	else begin
		resetErrors = resetErrors + 1;
		$display("%s: instrValid high during reset or in the cycle after it", testName);
	end

	task automatic loadImage();
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			@(posedge CLK);
			#2;
			loadEn = 1'b1;
			loadAddr = itcmWordAddrT'(i);
			loadData = image[i];
		end
		@(posedge CLK);
		#2;
		loadEn = 1'b0;
	endtask

	task automatic stepCycle(input logic randomReady);
		@(posedge CLK);
		#2;
		instrReady = randomReady ? drawReady() : 1'b1;
	endtask

	// fires a one-cycle redirect pulse and draws decode readiness as in any other cycle.
	task automatic fireRedirect(input pcT target, input logic randomReady);
		@(posedge CLK);
		#2;
		redirectEn = 1'b1;
		redirectPc = target;
		instrReady = randomReady ? drawReady() : 1'b1;
		@(posedge CLK);
		#2;
		redirectEn = 1'b0;
	endtask

	task automatic streamAccepted(input int count, input logic randomReady);
		int target;
		target = acceptCount + count;
		while (acceptCount < target) begin
			stepCycle(randomReady);
		end
	endtask

	task automatic reportCounts();
		$display("errors: %0d mismatch, %0d hold, %0d reset",
			mismatchErrors, holdErrors, resetErrors);
	endtask

	initial begin
		int gap;
		CLK = 1'b0;
		RSTn = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		redirectEn = 1'b0;
		redirectPc = '0;
		instrReady = 1'b0;
		rngState = SEED;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			image[i] = nextRand();
		end
		loadImage(); // the front end stays in reset while the ITCM fills.
		testName = "reset";
		repeat (RESET_CYCLES) @(posedge CLK);
		#2;
		RSTn = 1'b1;
		instrReady = 1'b1;

		testName = "sequential";
		streamAccepted(SEQ_COUNT, 1'b0);

		testName = "backpressure";
		streamAccepted(RANDOM_COUNT, 1'b1);

		testName = "redirect";
		for (int r = 0; r < REDIRECT_ROUNDS; r++) begin
			gap = int'(nextRand() % REDIRECT_GAP);
			repeat (gap) stepCycle(1'b1);
			fireRedirect(randomTarget(r[0]), 1'b1); // odd rounds land on a misaligned word.
			streamAccepted(REDIRECT_AFTER, 1'b1);
		end

		testName = "wrap";
		fireRedirect(64'h0000_0000_0000_1ffc, 1'b0); // the last word takes its high half from row 0.
		streamAccepted(WRAP_COUNT, 1'b0);
		fireRedirect(64'h0000_0000_0000_3ff8, 1'b0); // aliases to the last even row.
		streamAccepted(WRAP_COUNT, 1'b0);
		fireRedirect(64'hffff_ffff_ffff_fffc, 1'b0); // aliases to the last word and the PC wraps too.
		streamAccepted(WRAP_COUNT, 1'b0);

		stepCycle(1'b0);
		reportCounts();
		if (mismatchErrors + holdErrors + resetErrors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: instructions stopped coming during %s", testName);
		reportCounts();
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/fetchTop.sv */
`default_nettype none

module fetchTop (
	input wire logic CLK,
	input wire logic RSTn,
	input wire logic loadEn,
	input wire itcmPkg::itcmWordAddrT loadAddr,
	input wire fetchPkg::instrT loadData,
	input wire logic redirectEn,
	input wire fetchPkg::pcT redirectPc,
	input wire logic instrReady,
	output logic instrValid,
	output fetchPkg::pcT instrPc,
	output fetchPkg::instrT instr
);
	import itcmPkg::*;
	import fetchPkg::*;

	logic fetchReq; // ITCM read port.
	pcT fetchAddr;
	logic fetchTaken;
	logic fetchValid;
	fetchWindowT fetchData;

	logic pushEn; // queue write side.
	fetchPacketT pushPacket;
	logic flush; // redirect flush to queue and splitter.

	logic headValid; // queue read side.
	fetchPacketT headPacket;
	logic popEn;
	queueCountT queueCount; // feeds the request credit.

	fetchCtrl i_fetchCtrl (
		.CLK(CLK),
		.RSTn(RSTn),
		.redirectEn(redirectEn),
		.redirectPc(redirectPc),
		.fetchValid(fetchValid),
		.fetchData(fetchData),
		.queueCount(queueCount),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr),
		.fetchTaken(fetchTaken),
		.pushEn(pushEn),
		.pushPacket(pushPacket),
		.flush(flush)
	);

	itcmBanked i_itcmBanked (
		.CLK(CLK),
		.RSTn(RSTn),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr),
		.fetchTaken(fetchTaken),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.fetchValid(fetchValid),
		.fetchData(fetchData)
	);

	fetchQueue i_fetchQueue (
		.CLK(CLK),
		.RSTn(RSTn),
		.flush(flush),
		.pushEn(pushEn),
		.pushPacket(pushPacket),
		.popEn(popEn),
		.headValid(headValid),
		.headPacket(headPacket),
		.queueCount(queueCount)
	);

	instrSplitter i_instrSplitter (
		.CLK(CLK),
		.RSTn(RSTn),
		.flush(flush),
		.headValid(headValid),
		.headPacket(headPacket),
		.instrReady(instrReady),
		.popEn(popEn),
		.instrValid(instrValid),
		.instrPc(instrPc),
		.instr(instr)
	);

endmodule

`default_nettype wire

/* design/instrSplitter.sv */
`default_nettype none

module instrSplitter (
	input wire logic CLK,
	input wire logic RSTn,
	input wire logic flush,
	input wire logic headValid,
	input wire fetchPkg::fetchPacketT headPacket,
	input wire logic instrReady,
	output logic popEn,
	output logic instrValid,
	output fetchPkg::pcT instrPc,
	output fetchPkg::instrT instr
);
	import fetchPkg::*;

	logic slotQ; // set once the low instruction of the head has gone out.
	logic curSlot; // slot handed out this cycle, 1 is the high word.
	logic lastSlot; // nothing of the head is left after this slot.
	logic accept; // decode takes the instruction this cycle.

	// a packet whose low slot is already consumed starts on the high one.
	assign curSlot = slotQ || !headPacket.slotMask[0];
	assign lastSlot = curSlot || !headPacket.slotMask[1];

	// nothing is offered in a redirect cycle, the head is from the old path.
	assign instrValid = headValid && headPacket.slotMask[curSlot] && !flush;
	assign accept = instrValid && instrReady;

	assign instr = curSlot ? headPacket.window[63:32] : headPacket.window[31:0];
	assign instrPc = curSlot ? headPacket.pc + 64'd4 : headPacket.pc;

	assign popEn = accept && lastSlot; // the head is done once its last slot goes.

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			slotQ <= 1'b0;
		end else if (flush || popEn) begin
			slotQ <= 1'b0; // the next head starts from its low word.
		end else if (accept) begin
			slotQ <= 1'b1; // low word taken, high word next.
		end
	end

endmodule

`default_nettype wire

/* design/fetchQueue.sv */
`default_nettype none

module fetchQueue (
	input wire logic CLK,
	input wire logic RSTn,
	input wire logic flush,
	input wire logic pushEn,
	input wire fetchPkg::fetchPacketT pushPacket,
	input wire logic popEn,
	output logic headValid,
	output fetchPkg::fetchPacketT headPacket,
	output fetchPkg::queueCountT queueCount
);
	import fetchPkg::*;

	fetchPacketT entries [QUEUE_DEPTH]; // circular buffer of fetched windows.
	queuePtrT wrPtr; // next free entry.
	queuePtrT rdPtr; // oldest entry.
	logic doPush;
	logic doPop;

	// a push that coincides with a flush belongs to the old path.
	assign doPush = pushEn && !flush;
	assign doPop = popEn && headValid && !flush;

	assign headValid = queueCount != '0;
	assign headPacket = entries[rdPtr]; // a push is seen here one cycle later.

	always_ff @(posedge CLK) begin
		if (doPush) begin
			entries[wrPtr] <= pushPacket;
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			wrPtr <= '0;
			rdPtr <= '0;
			queueCount <= '0;
		end else if (flush) begin
			wrPtr <= '0; // emptied in one cycle.
			rdPtr <= '0;
			queueCount <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= queuePtrT'(wrPtr + 1'b1); // depth is a power of two, so it wraps.
			end
			if (doPop) begin
				rdPtr <= queuePtrT'(rdPtr + 1'b1);
			end
			case ({doPush, doPop})
				2'b10: queueCount <= queueCountT'(queueCount + 1'b1);
				2'b01: queueCount <= queueCountT'(queueCount - 1'b1);
				default: queueCount <= queueCount; // both or neither leave it as it is.
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/fetchCtrl.sv */
`default_nettype none

module fetchCtrl (
	input wire logic CLK,
	input wire logic RSTn,
	input wire logic redirectEn,
	input wire fetchPkg::pcT redirectPc,
	input wire logic fetchValid,
	input wire itcmPkg::fetchWindowT fetchData,
	input wire fetchPkg::queueCountT queueCount,
	output logic fetchReq,
	output fetchPkg::pcT fetchAddr,
	output logic fetchTaken,
	output logic pushEn,
	output fetchPkg::fetchPacketT pushPacket,
	output logic flush
);
	import fetchPkg::*;

	pcT nextPc; // address of the next window to request.
	pcT reqPc; // address of the window currently in the ITCM.
	logic respStale; // stale flag for the window presented this cycle.
	logic hasCredit; // queue has room for one more window after those in flight.

	// a redirect flushes everything behind the control block at once.
	assign flush = redirectEn;

	// no request leaves in a redirect cycle, so the only window in flight then
	// is the one that arrives together with the redirect.
	assign respStale = redirectEn;

	// every stale or live response is claimed in the cycle it shows up.
	assign fetchTaken = fetchValid;
	assign pushEn = fetchValid && !respStale;

	always_comb begin
		pushPacket.pc = reqPc;
		pushPacket.window = fetchData;
		pushPacket.slotMask = 2'b11; // both instructions of a fresh window are pending.
	end

	// the live response being pushed now still counts against the queue because
	// its entry does not show in queueCount until the next cycle.
	assign hasCredit = (int'(queueCount) + int'(pushEn)) < QUEUE_DEPTH;

	assign fetchReq = hasCredit && !flush; // no request leaves in a redirect cycle.
	assign fetchAddr = nextPc;

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			nextPc <= RESET_PC;
			reqPc <= RESET_PC;
		end else begin
			if (redirectEn) begin
				nextPc <= {redirectPc[63:2], 2'b00}; // the low two bits are ignored.
			end else if (fetchReq) begin
				nextPc <= nextPc + 64'd8; // one window is two instructions.
				reqPc <= nextPc;
			end
		end
	end

endmodule

`default_nettype wire

/* itcm/itcmBanked.sv */
`default_nettype none

module itcmBanked (
	input wire logic CLK,
	input wire logic RSTn,
	input wire logic fetchReq,
	input wire fetchPkg::pcT fetchAddr,
	input wire logic fetchTaken,
	input wire logic loadEn,
	input wire itcmPkg::itcmWordAddrT loadAddr,
	input wire fetchPkg::instrT loadData,
	output logic fetchValid,
	output itcmPkg::fetchWindowT fetchData
);
	import itcmPkg::*;
	import fetchPkg::*;

	instrT oddBank [ITCM_DEPTH]; // words whose address bit 2 is set.
	instrT evenBank [ITCM_DEPTH]; // words whose address bit 2 is clear.

	itcmWordAddrT reqWord; // word index of the request, upper PC bits dropped.
	itcmRowT oddRow; // odd bank row for the request.
	itcmRowT evenRow; // even bank row, one further on for a misaligned start.
	logic misaligned; // window starts on an odd word.
	instrT oddWord;
	instrT evenWord;

	assign reqWord = fetchAddr[ITCM_AW+2:2]; // addresses alias modulo 8 KiB.
	assign misaligned = reqWord[0];
	assign oddRow = reqWord[ITCM_AW:1];
	assign evenRow = misaligned ? itcmRowT'(oddRow + 1'b1) : oddRow; // wraps to row 0 at the top.

	assign oddWord = oddBank[oddRow];
	assign evenWord = evenBank[evenRow];

	// the load port writes one word per cycle into the bank picked by bit 0.
	always_ff @(posedge CLK) begin
		if (loadEn && loadAddr[0]) begin
			oddBank[loadAddr[ITCM_AW:1]] <= loadData; // odd word.
		end
		if (loadEn && !loadAddr[0]) begin
			evenBank[loadAddr[ITCM_AW:1]] <= loadData; // even word.
		end
	end

	// the window register only moves on a request and holds otherwise.
	always_ff @(posedge CLK) begin
		if (fetchReq) begin
			fetchData <= misaligned ? {evenWord, oddWord} : {oddWord, evenWord}; // requested word low.
		end
	end

	// valid is level-held: a new request sets it, even over an unclaimed one.
	// taken without a new request clears it, and with neither it waits.
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			fetchValid <= 1'b0;
		end else if (fetchReq) begin
			fetchValid <= 1'b1; // a new window replaces whatever was there.
		end else if (fetchTaken) begin
			fetchValid <= 1'b0; // old window claimed and nothing new behind it.
		end
	end

endmodule

`default_nettype wire

/* common/fetchPkg.sv */
`default_nettype none

package fetchPkg;

	// a byte address in the core's address space.
	typedef logic [63:0] pcT;

	// one uncompressed instruction word.
	typedef logic [31:0] instrT;

	localparam int QUEUE_DEPTH = 4; // fetch windows the queue can buffer.
	localparam pcT RESET_PC = 64'h0; // first fetch address after reset.

	// the queue count takes QUEUE_DEPTH+1 values, the pointers QUEUE_DEPTH.
	typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queueCountT;
	typedef logic [$clog2(QUEUE_DEPTH)-1:0] queuePtrT;

	// one fetched window on its way from the ITCM to decode.
	typedef struct packed {
		pcT pc; // address of the low instruction in the window.
		itcmPkg::fetchWindowT window; // low word at pc, high word at pc + 4.
		logic [1:0] slotMask; // set bits mark instructions still to hand out.
	} fetchPacketT;

endpackage

`default_nettype wire

/* common/itcmPkg.sv */
`default_nettype none

package itcmPkg;

	// each bank holds one 32-bit instruction per row.
	localparam int ITCM_AW = 10; // row address bits per bank.
	localparam int ITCM_DEPTH = 2 ** ITCM_AW; // rows per bank, 1024 here.

	// a row index, valid in the odd bank and in the even bank alike.
	typedef logic [ITCM_AW-1:0] itcmRowT;

	// a word index across both banks.
	// bit 0 picks the bank (1 = odd) and the upper bits pick the row.
	typedef logic [ITCM_AW:0] itcmWordAddrT;

	// two consecutive instructions, the requested one in the low half.
	typedef logic [63:0] fetchWindowT;

endpackage

`default_nettype wire
